/* design/dmc_macros.svh */
// Widths, register codes, control and status bit positions, address base and output step
`ifndef DMC_MACROS_SVH
`define DMC_MACROS_SVH

// Widths
`define DMC_DATA_W          8
`define DMC_ADDR_W          16
`define DMC_LEVEL_W         7
`define DMC_PERIOD_W        9
`define DMC_RATE_W          4
`define DMC_LEN_W           12
`define DMC_REG_W           3

// Register select codes
`define DMC_REG_CTRL        3'd0
`define DMC_REG_LOAD        3'd1
`define DMC_REG_ADDR        3'd2
`define DMC_REG_LEN         3'd3
`define DMC_REG_STATUS      3'd4

// Sample address space
`define DMC_ADDR_BASE       16'hC000
`define DMC_ADDR_WRAP       16'h8000

// Control and status bit positions
`define DMC_CTRL_LOOP_BIT   6
`define DMC_CTRL_IRQ_BIT    7
`define DMC_STAT_ACTIVE_BIT 4
`define DMC_STAT_IRQ_BIT    7

`define DMC_STEP            2   // Delta applied per output bit

`endif

/* design/dmc_pkg.sv */
// Vector types, register-select enum and rate-period table of the DMC channel
`include "dmc_macros.svh"

package dmc_pkg;

	typedef logic [`DMC_DATA_W-1:0]   dmc_byte_t;    // Bus byte
	typedef logic [`DMC_ADDR_W-1:0]   dmc_addr_t;    // Fetch address
	typedef logic [`DMC_LEVEL_W-1:0]  dmc_level_t;   // DAC level
	typedef logic [`DMC_RATE_W-1:0]   dmc_rate_t;    // Rate index
	typedef logic [`DMC_PERIOD_W-1:0] dmc_period_t;  // Audio clocks per output bit
	typedef logic [`DMC_LEN_W-1:0]    dmc_len_t;     // Bytes, value x 16 + 1

	typedef enum logic [`DMC_REG_W-1:0] {
		reg_ctrl   = `DMC_REG_CTRL,
		reg_load   = `DMC_REG_LOAD,
		reg_addr   = `DMC_REG_ADDR,
		reg_len    = `DMC_REG_LEN,
		reg_status = `DMC_REG_STATUS
	} dmc_reg_t;

	// Half of the CPU-cycle counts, so one entry is the tick spacing in aclk cycles
	localparam dmc_period_t dmc_rate_period [16] = '{
		9'd214, 9'd190, 9'd170, 9'd160,
		9'd143, 9'd127, 9'd113, 9'd107,
		9'd95,  9'd80,  9'd71,  9'd64,
		9'd53,  9'd42,  9'd36,  9'd27
	};

endpackage

/* design/dmc_reg_decode.sv */
// DMC register decode with control, address and length registers and write strobes
`timescale 1ns/1ps
`include "dmc_macros.svh"

module dmc_reg_decode (
	input  logic               aclk,
	input  logic               rst_n,
	input  logic               reg_wr,
	input  dmc_pkg::dmc_reg_t  reg_sel,
	input  dmc_pkg::dmc_byte_t wdata,
	output dmc_pkg::dmc_rate_t rate,
	output logic               loop_mode,
	output logic               irq_en,
	output dmc_pkg::dmc_addr_t start_addr,
	output dmc_pkg::dmc_len_t  length,
	output logic               load_level_wr,
	output logic               status_wr
);
	import dmc_pkg::*;

	logic      ctrl_wr;
	logic      addr_wr;
	logic      len_wr;
	dmc_byte_t addr_reg;  // Raw sample address byte
	dmc_byte_t len_reg;   // Raw sample length byte

	assign ctrl_wr       = reg_wr && (reg_sel == reg_ctrl);
	assign load_level_wr = reg_wr && (reg_sel == reg_load);
	assign addr_wr       = reg_wr && (reg_sel == reg_addr);
	assign len_wr        = reg_wr && (reg_sel == reg_len);
	assign status_wr     = reg_wr && (reg_sel == reg_status);

	// Start address steps in 64-byte pages from the base
	assign start_addr = dmc_addr_t'(`DMC_ADDR_BASE) + dmc_addr_t'({addr_reg, 6'b00_0000});
	assign length     = {len_reg, 4'b0001};  // Value x 16 + 1

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			rate      <= '0;
			loop_mode <= 1'b0;
			irq_en    <= 1'b0;
			addr_reg  <= '0;
			len_reg   <= '0;
		end else begin
			if (ctrl_wr) begin
				rate      <= wdata[`DMC_RATE_W-1:0];
				loop_mode <= wdata[`DMC_CTRL_LOOP_BIT];
				irq_en    <= wdata[`DMC_CTRL_IRQ_BIT];
			end
			if (addr_wr)
				addr_reg <= wdata;
			if (len_wr)
				len_reg <= wdata;
		end
	end

	// A write lands in exactly one register, never none and never two
	a_one_strobe: assert property (@(posedge aclk) disable iff (!rst_n)
		reg_wr |-> $onehot({ctrl_wr, load_level_wr, addr_wr, len_wr, status_wr}));

endmodule

/* design/dmc_rate_timer.sv */
// DMC rate timer, period down-counter from the rate table with a one-cycle tick
`timescale 1ns/1ps

module dmc_rate_timer (
	input  logic               aclk,
	input  logic               rst_n,
	input  dmc_pkg::dmc_rate_t rate,
	output logic               tick
);
	import dmc_pkg::*;

	dmc_period_t cnt;       // Cycles left until the next tick
	dmc_period_t period;    // Selected table entry
	logic        expired;

	assign period  = dmc_rate_period[rate];
	assign expired = (cnt == '0);

	// Reload at zero, so a period of P gives a tick every P cycles
	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else if (expired) begin
			cnt  <= period - 1'b1;
			tick <= 1'b1;
		end else begin
			cnt  <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

	// The shortest period is far above one, so tick never lasts two cycles
	a_tick_single: assert property (@(posedge aclk) disable iff (!rst_n)
		tick |=> !tick);

endmodule

/* design/dmc_output_unit.sv */
// DMC output unit with sample buffer, output shifter, bit counter and delta output counter
`timescale 1ns/1ps
`include "dmc_macros.svh"

module dmc_output_unit (
	input  logic                aclk,
	input  logic                rst_n,
	input  logic                tick,
	input  logic                pcm_strobe,
	input  logic                dma_req,
	input  dmc_pkg::dmc_byte_t  pcm_data,
	input  logic                load_level_wr,
	input  dmc_pkg::dmc_level_t load_level,
	output logic                buf_empty,
	output dmc_pkg::dmc_level_t dac_out
);
	import dmc_pkg::*;

	localparam dmc_level_t step     = dmc_level_t'(`DMC_STEP);
	localparam dmc_level_t up_limit = dmc_level_t'((2 ** `DMC_LEVEL_W) - 1 - `DMC_STEP);

	dmc_byte_t  buf_data;
	logic       buf_full;
	dmc_byte_t  shift_reg;
	logic [2:0] bit_cnt;    // Bits shifted out of the current byte
	logic       silent;     // Shifter has no sample behind it
	logic       take;
	logic       reload;

	assign take      = pcm_strobe && dma_req;
	assign reload    = tick && (bit_cnt == 3'd7);  // Eighth tick of a byte
	assign buf_empty = !buf_full;

	always_ff @(posedge aclk) begin
		if (take)
			buf_data <= pcm_data;
		if (reload && buf_full)
			shift_reg <= buf_data;
		else if (tick)
			shift_reg <= {1'b0, shift_reg[7:1]};  // LSB first
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			buf_full <= 1'b0;
			bit_cnt  <= '0;
			silent   <= 1'b1;
			dac_out  <= '0;
		end else begin
			if (take)
				buf_full <= 1'b1;
			else if (reload)
				buf_full <= 1'b0;  // Byte moves into the shifter
			if (tick)
				bit_cnt <= bit_cnt + 3'd1;
			if (reload)
				silent <= !buf_full;
			if (load_level_wr)
				dac_out <= load_level;  // Direct load wins over a step
			else if (tick && !silent) begin
				if (shift_reg[0] && (dac_out <= up_limit))
					dac_out <= dac_out + step;
				else if (!shift_reg[0] && (dac_out >= step))
					dac_out <= dac_out - step;
			end
		end
	end

	// A step moves the level by the step size or not at all, it never wraps
	a_step_saturates: assert property (@(posedge aclk) disable iff (!rst_n)
		(tick && !load_level_wr) |=>
			((dac_out == $past(dac_out)) ||
			 (dac_out == $past(dac_out) + `DMC_STEP) ||
			 (dac_out + `DMC_STEP == $past(dac_out))));

endmodule

/* design/dmc_fetch_unit.sv */
// DMC fetch unit with address and byte counters, fetch request, loop, interrupt and status
`timescale 1ns/1ps
`include "dmc_macros.svh"

module dmc_fetch_unit (
	input  logic               aclk,
	input  logic               rst_n,
	input  logic               buf_empty,
	input  logic               pcm_strobe,
	input  logic               status_wr,
	input  logic               enable_bit,
	input  logic               irq_en,
	input  logic               loop_mode,
	input  dmc_pkg::dmc_addr_t start_addr,
	input  dmc_pkg::dmc_len_t  length,
	output logic               dma_req,
	output dmc_pkg::dmc_addr_t dmc_addr,
	output logic               irq,
	output dmc_pkg::dmc_byte_t status
);
	import dmc_pkg::*;

	dmc_addr_t addr_cnt;
	dmc_len_t  bytes_left;   // Remaining fetches
	logic      take;         // Fetch answered this cycle
	logic      active;
	logic      last_byte;
	logic      disable_wr;
	dmc_addr_t addr_next;

	assign take       = dma_req && pcm_strobe;
	assign active     = (bytes_left != '0);
	assign last_byte  = take && (bytes_left == dmc_len_t'(1));
	assign disable_wr = status_wr && !enable_bit;
	assign dmc_addr   = addr_cnt;

	// FFFF rolls over into the upper half of the CPU space
	assign addr_next = (addr_cnt == '1) ? dmc_addr_t'(`DMC_ADDR_WRAP) : addr_cnt + 1'b1;

	always_comb begin
		status = '0;
		status[`DMC_STAT_ACTIVE_BIT] = active;
		status[`DMC_STAT_IRQ_BIT]    = irq;
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			addr_cnt   <= dmc_addr_t'(`DMC_ADDR_BASE);
			bytes_left <= '0;
		end else if (disable_wr) begin
			bytes_left <= '0;  // Playback stops
		end else if (status_wr && !active) begin
			addr_cnt   <= start_addr;  // Restart from the registers
			bytes_left <= length;
		end else if (take) begin
			if (last_byte && loop_mode) begin
				addr_cnt   <= start_addr;
				bytes_left <= length;
			end else begin
				addr_cnt   <= addr_next;
				bytes_left <= bytes_left - 1'b1;
			end
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			dma_req <= 1'b0;
			irq     <= 1'b0;
		end else begin
			if (disable_wr || take)
				dma_req <= 1'b0;
			else if (buf_empty && active)
				dma_req <= 1'b1;  // Held until answered
			if (status_wr || !irq_en)
				irq <= 1'b0;
			else if (last_byte && !loop_mode)
				irq <= 1'b1;  // End of sample
		end
	end

	// A pending request always has bytes left behind it
	a_no_req_when_done: assert property (@(posedge aclk) disable iff (!rst_n)
		dma_req |-> active);

endmodule

/* design/dmc_channel.sv */
// DMC channel top level connecting register decode, rate timer, output unit and fetch unit
`timescale 1ns/1ps
`include "dmc_macros.svh"

module dmc_channel (
	input  logic                aclk,
	input  logic                rst_n,
	input  logic                reg_wr,
	input  dmc_pkg::dmc_reg_t   reg_sel,
	input  dmc_pkg::dmc_byte_t  wdata,
	input  logic                pcm_strobe,
	input  dmc_pkg::dmc_byte_t  pcm_data,
	output logic                dma_req,
	output dmc_pkg::dmc_addr_t  dmc_addr,
	output dmc_pkg::dmc_level_t dac_out,
	output logic                irq,
	output dmc_pkg::dmc_byte_t  status
);
	import dmc_pkg::*;

	dmc_rate_t rate;
	logic      loop_mode;
	logic      irq_en;
	dmc_addr_t start_addr;
	dmc_len_t  length;
	logic      load_level_wr;
	logic      status_wr;
	logic      tick;
	logic      buf_empty;

	dmc_reg_decode u_reg_decode (
		.aclk          (aclk),
		.rst_n         (rst_n),
		.reg_wr        (reg_wr),
		.reg_sel       (reg_sel),
		.wdata         (wdata),
		.rate          (rate),
		.loop_mode     (loop_mode),
		.irq_en        (irq_en),
		.start_addr    (start_addr),
		.length        (length),
		.load_level_wr (load_level_wr),
		.status_wr     (status_wr)
	);

	dmc_rate_timer u_rate_timer (
		.aclk  (aclk),
		.rst_n (rst_n),
		.rate  (rate),
		.tick  (tick)
	);

	dmc_output_unit u_output_unit (
		.aclk          (aclk),
		.rst_n         (rst_n),
		.tick          (tick),
		.pcm_strobe    (pcm_strobe),
		.dma_req       (dma_req),
		.pcm_data      (pcm_data),
		.load_level_wr (load_level_wr),
		.load_level    (wdata[`DMC_LEVEL_W-1:0]),        // Direct load value
		.buf_empty     (buf_empty),
		.dac_out       (dac_out)
	);

	dmc_fetch_unit u_fetch_unit (
		.aclk       (aclk),
		.rst_n      (rst_n),
		.buf_empty  (buf_empty),
		.pcm_strobe (pcm_strobe),
		.status_wr  (status_wr),
		.enable_bit (wdata[`DMC_STAT_ACTIVE_BIT]),        // Enable shares the active bit
		.irq_en     (irq_en),
		.loop_mode  (loop_mode),
		.start_addr (start_addr),
		.length     (length),
		.dma_req    (dma_req),
		.dmc_addr   (dmc_addr),
		.irq        (irq),
		.status     (status)
	);

endmodule

/* tests/dmc_tb_ref.svh */
// Reference functions for start address, byte length, rate period, fetch address and delta step
`ifndef DMC_TB_REF_SVH
`define DMC_TB_REF_SVH

// Base plus 64 bytes per register step
function automatic dmc_addr_t ref_start_addr(input dmc_byte_t val);
	return dmc_addr_t'(16'hC000 + 32'(val) * 64);
endfunction

function automatic int ref_length(input dmc_byte_t val);
	return int'(val) * 16 + 1;
endfunction

function automatic int ref_period(input dmc_rate_t rate);
	return int'(dmc_rate_period[rate]);
endfunction

// Address of fetch n, counting from the start and wrapping at FFFF
function automatic dmc_addr_t ref_fetch_addr(input dmc_addr_t start, input int len, input int n);
	dmc_addr_t a;
	int        k;
	a = start;
	for (k = 0; k < (n % len); k++) begin
		if (a == 16'hFFFF)
			a = 16'h8000;
		else
			a = a + 16'd1;
	end
	return a;
endfunction

// One output bit applied to the level, saturating at both ends
function automatic dmc_level_t ref_step(input dmc_level_t lvl, input logic b);
	if (b && lvl <= 7'd125)
		return lvl + 7'd2;
	if (!b && lvl >= 7'd2)
		return lvl - 7'd2;
	return lvl;
endfunction

`endif

/* tests/dmc_channel_tb.sv */
// Testbench for the DMC channel with memory responder, fetch monitor, reference checks and watchdog
`timescale 1ns/1ps
`include "dmc_macros.svh"

module dmc_channel_tb;
	import dmc_pkg::*;
	`include "dmc_tb_ref.svh"

	logic       aclk;
	logic       rst_n;
	logic       reg_wr;
	dmc_reg_t   reg_sel;
	dmc_byte_t  wdata;
	logic       pcm_strobe;
	dmc_byte_t  pcm_data;
	logic       dma_req;
	dmc_addr_t  dmc_addr;
	dmc_level_t dac_out;
	logic       irq;
	dmc_byte_t  status;

	dmc_byte_t  mem [0:65535];   // Sample memory
	int         errors;
	int         fetch_count;     // Rising requests seen
	dmc_addr_t  exp_start;
	int         exp_len;
	logic       loop_check;      // Irq must stay low
	logic       prev_req;

	dmc_channel dmc_channel_i (
		.aclk(aclk), .rst_n(rst_n), .reg_wr(reg_wr), .reg_sel(reg_sel), .wdata(wdata),
		.pcm_strobe(pcm_strobe), .pcm_data(pcm_data), .dma_req(dma_req),
		.dmc_addr(dmc_addr), .dac_out(dac_out), .irq(irq), .status(status)
	);

	initial begin
		aclk = 1'b0;
		forever #50 aclk = ~aclk;
	end

	task automatic check_level(input string name, input dmc_level_t exp, input dmc_level_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input dmc_addr_t exp, input dmc_addr_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic write_reg(input dmc_reg_t sel, input dmc_byte_t data);
		@(negedge aclk);
		reg_wr  = 1'b1;
		reg_sel = sel;
		wdata   = data;
		@(negedge aclk);
		reg_wr  = 1'b0;
	endtask

	// Memory responder with a random latency
	initial begin
		int delay;
		pcm_strobe = 1'b0;
		pcm_data   = '0;
		forever begin
			@(negedge aclk);
			if (dma_req) begin
				delay = $urandom_range(0, 5);
				repeat (delay) @(negedge aclk);
				if (dma_req) begin
					pcm_strobe = 1'b1;
					pcm_data   = mem[dmc_addr];
					@(negedge aclk);
					pcm_strobe = 1'b0;
				end
			end
		end
	end

	// Every new request must point at the next sample address
	always @(negedge aclk) begin
		if (rst_n && dma_req && !prev_req) begin
			check_addr("fetch address", ref_fetch_addr(exp_start, exp_len, fetch_count), dmc_addr);
			if (loop_check)
				check_bit("irq in loop mode", 1'b0, irq);
			fetch_count++;
		end
		prev_req = dma_req;
	end

	// Watchdog sized from both playback tests
	initial begin
		int limit;
		limit = (ref_length(8'h05) + ref_length(8'h01) + 5) * 8 * ref_period(4'hF) * 2 + 2000;
		repeat (limit) @(posedge aclk);
		$display("Watchdog expired after %0d cycles, the DUT stopped making progress", limit);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		dmc_level_t exp_lvl;
		dmc_byte_t  smp;
		int         n;
		int         b;
		int         i;
		void'($urandom(32'h3f91da08));
		reg_wr      = 1'b0;
		reg_sel     = reg_ctrl;
		wdata       = '0;
		rst_n       = 1'b0;
		errors      = 0;
		fetch_count = 0;
		exp_start   = 16'hC000;
		exp_len     = 1;
		loop_check  = 1'b0;
		prev_req    = 1'b0;
		for (i = 0; i < 65536; i++)
			mem[i] = dmc_byte_t'($urandom);
		repeat (3) @(posedge aclk);
		@(negedge aclk);
		rst_n = 1'b1;

		// Direct load
		write_reg(reg_load, 8'hD5);
		check_level("direct load", 7'h55, dac_out);

		// One-shot playback across the FFFF wrap, with interrupt
		exp_start   = ref_start_addr(8'hFF);
		exp_len     = ref_length(8'h05);
		fetch_count = 0;
		write_reg(reg_ctrl, 8'h8F);   // Irq enable, rate 15
		write_reg(reg_addr, 8'hFF);
		write_reg(reg_len, 8'h05);
		write_reg(reg_load, 8'h40);
		write_reg(reg_status, 8'h10);
		while (status[`DMC_STAT_ACTIVE_BIT])
			@(negedge aclk);
		check_bit("irq after last fetch", 1'b1, irq);
		check_bit("status irq bit", 1'b1, status[`DMC_STAT_IRQ_BIT]);
		repeat (17 * ref_period(4'hF) + 20) @(negedge aclk);
		if (fetch_count != exp_len) begin
			$display("Fetch count wrong: %0d requests seen, %0d wanted", fetch_count, exp_len);
			errors++;
		end
		exp_lvl = 7'h40;
		for (n = 0; n < exp_len; n++) begin
			smp = mem[ref_fetch_addr(exp_start, exp_len, n)];
			for (b = 0; b < 8; b++)
				exp_lvl = ref_step(exp_lvl, smp[b]);
		end
		check_level("final level", exp_lvl, dac_out);
		write_reg(reg_status, 8'h00);
		check_bit("irq after status write", 1'b0, irq);
		check_bit("status irq after clear", 1'b0, status[`DMC_STAT_IRQ_BIT]);

		// Looping playback, then disable
		exp_start   = ref_start_addr(8'h10);
		exp_len     = ref_length(8'h01);
		fetch_count = 0;
		loop_check  = 1'b1;
		write_reg(reg_ctrl, 8'hCF);   // Irq enable, loop, rate 15
		write_reg(reg_addr, 8'h10);
		write_reg(reg_len, 8'h01);
		write_reg(reg_status, 8'h10);
		while (fetch_count < exp_len + 5)
			@(negedge aclk);
		loop_check = 1'b0;
		check_bit("irq in loop mode", 1'b0, irq);
		check_bit("active while looping", 1'b1, status[`DMC_STAT_ACTIVE_BIT]);
		write_reg(reg_status, 8'h00);
		check_bit("active after disable", 1'b0, status[`DMC_STAT_ACTIVE_BIT]);
		for (i = 0; i < 300; i++) begin
			@(negedge aclk);
			if (dma_req) begin
				$display("Fetch request raised after playback was disabled");
				errors++;
				break;
			end
		end

		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+design
+incdir+tests
design/dmc_pkg.sv
design/dmc_reg_decode.sv
design/dmc_rate_timer.sv
design/dmc_output_unit.sv
design/dmc_fetch_unit.sv
design/dmc_channel.sv
tests/dmc_channel_tb.sv

/* Makefile */
# Verilator lint, simulation and cleanup for the DMC channel

VERILATOR ?= verilator
FILELIST  ?= vlog.f
RTL_TOP   ?= dmc_channel
TB_TOP    ?= dmc_channel_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP) | tee $(LOG)
	grep -q -- '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
